//--- verilog/core_pkg.sv
// core_pkg: shared widths, CSR map, opcodes, credit counts and stage packets of the core
`default_nettype none

package core_pkg;

  // data and instruction words
  typedef logic [31:0] xlen_t;
  // byte address into the instruction space
  typedef logic [31:0] pc_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [11:0] csr_addr_t;
  typedef logic [6:0]  opcode_t;
  // wide enough for 0..2 credits plus headroom to catch an overflow
  typedef logic [1:0]  credit_t;

  // csr map
  localparam csr_addr_t CSR_MISELECT = 12'h350;
  localparam csr_addr_t CSR_MCYCLE   = 12'hB00;
  localparam csr_addr_t CSR_MINSTRET = 12'hB02;
  // custom csr, low byte goes to the board leds
  localparam csr_addr_t CSR_LED      = 12'h7C0;

  // major opcodes of the supported subset
  localparam opcode_t OP_OPIMM  = 7'b0010011;
  localparam opcode_t OP_AUIPC  = 7'b0010111;
  localparam opcode_t OP_JAL    = 7'b1101111;
  localparam opcode_t OP_JALR   = 7'b1100111;
  localparam opcode_t OP_SYSTEM = 7'b1110011;

  // decode queue depth, also the fetch credit count after reset
  localparam credit_t FETCH_CREDITS  = 2'd2;
  // credits toward the retire consumer after reset
  localparam credit_t RETIRE_CREDITS = 2'd2;

  localparam int ROM_WORDS = 1024;

  // decoded operation, the csr immediate forms use use_imm
  typedef enum logic [2:0] {
    ADDI, AUIPC, JAL, JALR, CSRRW, CSRRS, CSRRC, NOP
  } op_e;

  typedef struct packed {
    pc_t   pc;
    xlen_t instr;
    logic  epoch;
  } fetch_pkt_s;

  typedef struct packed {
    pc_t       pc;
    xlen_t     instr;
    op_e       op;
    reg_idx_t  rd;
    reg_idx_t  rs1;
    logic      use_imm;
    xlen_t     imm;
    csr_addr_t csr_addr;
    logic      epoch;
  } dec_pkt_s;

  typedef struct packed {
    pc_t      pc;
    reg_idx_t rd;
    xlen_t    value;
    xlen_t    instr;
  } retire_s;

endpackage

`default_nettype wire

//--- verilog/rom.sv
// rom: word-addressed instruction memory with a combinational read port
`default_nettype none

module rom #(
  parameter int MEM_WORDS = core_pkg::ROM_WORDS
) (
  input  wire clk,
  input  wire core_pkg::pc_t address,
  output core_pkg::xlen_t data_out
);

  // one instruction word per entry
  core_pkg::xlen_t mem [MEM_WORDS];

  // image shared with the testbench model
  initial begin
    $readmemh("verilog/program.hex", mem);
  end

  // byte address to word index, low two bits ignored
  always_comb begin
    data_out = mem[address[$clog2(MEM_WORDS)+1:2]];
  end

  // fetch never runs off the end of the image
  // upper pc bits would otherwise alias silently
  assert property (@(posedge clk) address[31:2] < MEM_WORDS)
    else $error("fetch address 0x%08h outside the rom", address);

endmodule

`default_nettype wire

//--- verilog/fetch_stage.sv
// fetch_stage: program counter, epoch bit and credit-limited issue toward decode
`default_nettype none

module fetch_stage (
  input  wire clk,
  input  wire arst_n,
  input  wire redirect_valid,
  input  wire core_pkg::pc_t redirect_pc,
  input  wire decode_credit,
  output core_pkg::pc_t rom_addr,
  input  wire core_pkg::xlen_t rom_data,
  output logic fetch_valid,
  output core_pkg::fetch_pkt_s fetch_pkt
);

  core_pkg::pc_t     pc;
  logic              epoch;
  core_pkg::credit_t credits;
  logic              issue;

  // rom is read straight from the current pc
  assign rom_addr = pc;

  // one issue per cycle while decode has room
  assign issue = (credits != '0);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc          <= '0;
      epoch       <= 1'b0;
      credits     <= core_pkg::FETCH_CREDITS;
      fetch_valid <= 1'b0;
    end else begin
      fetch_valid <= issue;
      // spend one per issue, get one back per freed queue entry
      credits <= credits - core_pkg::credit_t'(issue)
                         + core_pkg::credit_t'(decode_credit);
      // redirect wins over the sequential step
      // a packet issued this cycle still carries the old epoch
      if (redirect_valid) begin
        pc    <= redirect_pc;
        epoch <= ~epoch;
      end else if (issue) begin
        pc <= pc + 32'd4;
      end
    end
  end

  // payload only, qualified by fetch_valid
  always_ff @(posedge clk) begin
    if (issue) begin
      fetch_pkt.pc    <= pc;
      fetch_pkt.instr <= rom_data;
      fetch_pkt.epoch <= epoch;
    end
  end

  // decode never returns more credits than it was given
  assert property (@(posedge clk) disable iff (!arst_n)
                   credits <= core_pkg::FETCH_CREDITS)
    else $error("fetch holds more credits than decode has entries");

endmodule

`default_nettype wire

//--- verilog/decode_stage.sv
// decode_stage: two-entry fetch queue, field and immediate decode, stale-epoch drop
`default_nettype none

module decode_stage (
  input  wire clk,
  input  wire arst_n,
  input  wire fetch_valid,
  input  wire core_pkg::fetch_pkt_s fetch_pkt,
  input  wire cur_epoch,
  output logic decode_credit,
  output logic dec_valid,
  output core_pkg::dec_pkt_s dec_pkt,
  input  wire exec_ready
);

  // one entry per fetch credit
  core_pkg::fetch_pkt_s q [core_pkg::FETCH_CREDITS];
  logic                 wr_ptr;
  logic                 rd_ptr;
  core_pkg::credit_t    count;
  core_pkg::fetch_pkt_s head;
  core_pkg::xlen_t      instr;
  logic                 head_valid;
  logic                 stale;
  logic                 pop;

  assign head       = q[rd_ptr];
  assign instr      = head.instr;
  assign head_valid = (count != '0);
  // fetched before the last redirect
  assign stale      = (head.epoch != cur_epoch);
  assign dec_valid  = head_valid && !stale;
  // leave on a handshake, or silently when stale
  assign pop        = head_valid && (stale || exec_ready);
  // every freed entry goes back to fetch as a credit
  assign decode_credit = pop;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= '0;
    end else begin
      if (fetch_valid) wr_ptr <= ~wr_ptr;
      if (pop) rd_ptr <= ~rd_ptr;
      count <= count + core_pkg::credit_t'(fetch_valid) - core_pkg::credit_t'(pop);
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_valid) q[wr_ptr] <= fetch_pkt;
  end

  always_comb begin
    dec_pkt.pc       = head.pc;
    dec_pkt.instr    = instr;
    dec_pkt.epoch    = head.epoch;
    dec_pkt.rd       = instr[11:7];
    dec_pkt.rs1      = instr[19:15];
    dec_pkt.csr_addr = instr[31:20];
    dec_pkt.use_imm  = 1'b0;
    // i-type by default
    dec_pkt.imm      = {{20{instr[31]}}, instr[31:20]};
    dec_pkt.op       = core_pkg::NOP;
    case (instr[6:0])
      core_pkg::OP_OPIMM: begin
        // only funct3 000 is in the subset
        if (instr[14:12] == 3'b000) dec_pkt.op = core_pkg::ADDI;
      end
      core_pkg::OP_AUIPC: begin
        dec_pkt.op  = core_pkg::AUIPC;
        dec_pkt.imm = {instr[31:12], 12'h000};
      end
      core_pkg::OP_JAL: begin
        dec_pkt.op  = core_pkg::JAL;
        dec_pkt.imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      end
      core_pkg::OP_JALR: dec_pkt.op = core_pkg::JALR;
      core_pkg::OP_SYSTEM: begin
        // funct3 bit 2 picks the zimm form
        case (instr[13:12])
          2'b01:   dec_pkt.op = core_pkg::CSRRW;
          2'b10:   dec_pkt.op = core_pkg::CSRRS;
          2'b11:   dec_pkt.op = core_pkg::CSRRC;
          default: dec_pkt.op = core_pkg::NOP;
        endcase
        dec_pkt.use_imm = instr[14];
        if (instr[14]) dec_pkt.imm = {27'd0, instr[19:15]};
      end
      default: dec_pkt.op = core_pkg::NOP;
    endcase
    // unknown opcodes retire without a destination
    if (dec_pkt.op == core_pkg::NOP) dec_pkt.rd = '0;
  end

  // fetch credit accounting keeps one slot free for every packet in flight
  assert property (@(posedge clk) disable iff (!arst_n)
                   fetch_valid |-> count < core_pkg::FETCH_CREDITS)
    else $error("fetch packet arrived at a full decode queue");

endmodule

`default_nettype wire

//--- verilog/csr_file.sv
// csr_file: miselect, mcycle, minstret and led registers with csr read-modify-write
`default_nettype none

module csr_file (
  input  wire clk,
  input  wire arst_n,
  input  wire csr_en,
  input  wire core_pkg::csr_addr_t csr_addr,
  input  wire core_pkg::op_e csr_op,
  input  wire core_pkg::xlen_t csr_wdata,
  input  wire retire_pulse,
  output core_pkg::xlen_t csr_rdata,
  output logic [7:0] led
);

  core_pkg::xlen_t miselect;
  core_pkg::xlen_t mcycle;
  core_pkg::xlen_t minstret;
  core_pkg::xlen_t led_csr;
  core_pkg::xlen_t new_val;
  logic            do_write;

  assign led = led_csr[7:0];

  // old value, also the rd result of the instruction
  always_comb begin
    case (csr_addr)
      core_pkg::CSR_MISELECT: csr_rdata = miselect;
      core_pkg::CSR_MCYCLE:   csr_rdata = mcycle;
      core_pkg::CSR_MINSTRET: csr_rdata = minstret;
      core_pkg::CSR_LED:      csr_rdata = led_csr;
      default:                csr_rdata = '0;
    endcase
  end

  always_comb begin
    case (csr_op)
      core_pkg::CSRRS: new_val = csr_rdata | csr_wdata;
      core_pkg::CSRRC: new_val = csr_rdata & ~csr_wdata;
      default:         new_val = csr_wdata;
    endcase
  end

  // set and clear with a zero source are pure reads
  assign do_write = csr_en && (csr_op == core_pkg::CSRRW || csr_wdata != '0);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      miselect <= '0;
      mcycle   <= '0;
      minstret <= '0;
      led_csr  <= '0;
    end else begin
      if (do_write && csr_addr == core_pkg::CSR_MISELECT) miselect <= new_val;
      if (do_write && csr_addr == core_pkg::CSR_LED) led_csr <= new_val;
      // a write replaces this cycle's count step
      if (do_write && csr_addr == core_pkg::CSR_MCYCLE) mcycle <= new_val;
      else mcycle <= mcycle + 32'd1;
      if (do_write && csr_addr == core_pkg::CSR_MINSTRET) minstret <= new_val;
      else if (retire_pulse) minstret <= minstret + 32'd1;
    end
  end

endmodule

`default_nettype wire

//--- verilog/execute_stage.sv
// execute_stage: register file, result and redirect logic, retire record and retire credits
`default_nettype none

module execute_stage (
  input  wire clk,
  input  wire arst_n,
  input  wire dec_valid,
  input  wire core_pkg::dec_pkt_s dec_pkt,
  output logic exec_ready,
  output logic redirect_valid,
  output core_pkg::pc_t redirect_pc,
  output logic cur_epoch,
  output logic csr_en,
  output core_pkg::csr_addr_t csr_addr,
  output core_pkg::op_e csr_op,
  output core_pkg::xlen_t csr_wdata,
  input  wire core_pkg::xlen_t csr_rdata,
  output logic retire_pulse,
  output logic retire_valid,
  output core_pkg::retire_s retire,
  input  wire retire_credit
);

  // x1..x31, x0 reads as zero
  core_pkg::xlen_t   regs [1:31];
  core_pkg::credit_t credits;
  core_pkg::xlen_t   rs1_val;
  core_pkg::xlen_t   result;
  core_pkg::xlen_t   wr_val;
  logic              writes_rd;
  logic              jump;
  logic              accept;

  // stall only on the outside consumer
  assign exec_ready   = (credits != '0);
  assign accept       = dec_valid && exec_ready;
  // retire happens in the accepting cycle
  assign retire_pulse = accept;

  assign rs1_val   = (dec_pkt.rs1 == '0) ? '0 : regs[dec_pkt.rs1];
  assign csr_addr  = dec_pkt.csr_addr;
  assign csr_op    = dec_pkt.op;
  assign csr_wdata = dec_pkt.use_imm ? dec_pkt.imm : rs1_val;

  always_comb begin
    result      = '0;
    writes_rd   = 1'b1;
    jump        = 1'b0;
    redirect_pc = '0;
    csr_en      = 1'b0;
    case (dec_pkt.op)
      core_pkg::ADDI:  result = rs1_val + dec_pkt.imm;
      core_pkg::AUIPC: result = dec_pkt.pc + dec_pkt.imm;
      core_pkg::JAL: begin
        result      = dec_pkt.pc + 32'd4;
        jump        = 1'b1;
        redirect_pc = dec_pkt.pc + dec_pkt.imm;
      end
      core_pkg::JALR: begin
        result      = dec_pkt.pc + 32'd4;
        jump        = 1'b1;
        // target lsb is cleared
        redirect_pc = (rs1_val + dec_pkt.imm) & ~32'd1;
      end
      core_pkg::CSRRW, core_pkg::CSRRS, core_pkg::CSRRC: begin
        csr_en = accept;
        result = csr_rdata;
      end
      default: writes_rd = 1'b0;
    endcase
  end

  assign redirect_valid = accept && jump;
  // x0 and non-writing ops report a zero value
  assign wr_val = (writes_rd && dec_pkt.rd != '0) ? result : '0;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      credits      <= core_pkg::RETIRE_CREDITS;
      cur_epoch    <= 1'b0;
      retire_valid <= 1'b0;
    end else begin
      credits <= credits - core_pkg::credit_t'(accept)
                         + core_pkg::credit_t'(retire_credit);
      // flips together with the fetch epoch
      if (redirect_valid) cur_epoch <= ~cur_epoch;
      retire_valid <= accept;
    end
  end

  // register file and retire payload
  always_ff @(posedge clk) begin
    if (accept && writes_rd && dec_pkt.rd != '0) regs[dec_pkt.rd] <= result;
    if (accept) begin
      retire.pc    <= dec_pkt.pc;
      retire.rd    <= dec_pkt.rd;
      retire.value <= wr_val;
      retire.instr <= dec_pkt.instr;
    end
  end

  // the consumer never hands back more credits than retires it has seen
  assert property (@(posedge clk) disable iff (!arst_n)
                   credits <= core_pkg::RETIRE_CREDITS)
    else $error("retire credit count above its initial value");

endmodule

`default_nettype wire

//--- verilog/core_top.sv
// core_top: fetch, decode and execute stages around the rom and the csr file
`default_nettype none

module core_top (
  input  wire clk,
  input  wire arst_n,
  output logic retire_valid,
  output core_pkg::retire_s retire,
  input  wire retire_credit,
  output logic [7:0] led
);

  // rom port
  core_pkg::pc_t        rom_addr;
  core_pkg::xlen_t      rom_data;
  // fetch to decode
  logic                 fetch_valid;
  core_pkg::fetch_pkt_s fetch_pkt;
  logic                 decode_credit;
  // decode to execute
  logic                 dec_valid;
  core_pkg::dec_pkt_s   dec_pkt;
  logic                 exec_ready;
  // execute back to fetch and decode
  logic                 redirect_valid;
  core_pkg::pc_t        redirect_pc;
  logic                 cur_epoch;
  // csr port
  logic                 csr_en;
  core_pkg::csr_addr_t  csr_addr;
  core_pkg::op_e        csr_op;
  core_pkg::xlen_t      csr_wdata;
  core_pkg::xlen_t      csr_rdata;
  logic                 retire_pulse;

  rom u_rom (
    .clk      (clk),
    .address  (rom_addr),
    .data_out (rom_data)
  );

  fetch_stage u_fetch (
    .clk            (clk),
    .arst_n         (arst_n),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .decode_credit  (decode_credit),
    .rom_addr       (rom_addr),
    .rom_data       (rom_data),
    .fetch_valid    (fetch_valid),
    .fetch_pkt      (fetch_pkt)
  );

  decode_stage u_decode (
    .clk           (clk),
    .arst_n        (arst_n),
    .fetch_valid   (fetch_valid),
    .fetch_pkt     (fetch_pkt),
    .cur_epoch     (cur_epoch),
    .decode_credit (decode_credit),
    .dec_valid     (dec_valid),
    .dec_pkt       (dec_pkt),
    .exec_ready    (exec_ready)
  );

  execute_stage u_execute (
    .clk            (clk),
    .arst_n         (arst_n),
    .dec_valid      (dec_valid),
    .dec_pkt        (dec_pkt),
    .exec_ready     (exec_ready),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .cur_epoch      (cur_epoch),
    .csr_en         (csr_en),
    .csr_addr       (csr_addr),
    .csr_op         (csr_op),
    .csr_wdata      (csr_wdata),
    .csr_rdata      (csr_rdata),
    .retire_pulse   (retire_pulse),
    .retire_valid   (retire_valid),
    .retire         (retire),
    .retire_credit  (retire_credit)
  );

  csr_file u_csr (
    .clk          (clk),
    .arst_n       (arst_n),
    .csr_en       (csr_en),
    .csr_addr     (csr_addr),
    .csr_op       (csr_op),
    .csr_wdata    (csr_wdata),
    .retire_pulse (retire_pulse),
    .csr_rdata    (csr_rdata),
    .led          (led)
  );

endmodule

`default_nettype wire

//--- dv/core_model.svh
// core reference model: steps the rom image one instruction per observed retire
`ifndef CORE_MODEL_SVH
`define CORE_MODEL_SVH

// architectural state
core_pkg::xlen_t image [core_pkg::ROM_WORDS];
core_pkg::xlen_t ref_regs [32];
core_pkg::pc_t   ref_pc;
core_pkg::xlen_t ref_miselect;
core_pkg::xlen_t ref_led;
core_pkg::xlen_t ref_instret;

// prediction for the current retire
core_pkg::pc_t      exp_pc;
core_pkg::reg_idx_t exp_rd;
core_pkg::xlen_t    exp_value;
core_pkg::xlen_t    exp_instr;
logic               exp_mcycle_read;
logic               exp_mcycle_write;
core_pkg::xlen_t    exp_mcycle_floor;
logic               exp_led_write;

task automatic load_image();
  $readmemh("verilog/program.hex", image);
endtask

task automatic reset_model();
  ref_pc       = '0;
  ref_miselect = '0;
  ref_led      = '0;
  ref_instret  = '0;
  foreach (ref_regs[i]) ref_regs[i] = '0;
endtask

// executes the instruction at ref_pc per the rv32 encoding
task automatic step_model();
  core_pkg::xlen_t ins;
  core_pkg::xlen_t rs1_val;
  core_pkg::xlen_t src;
  core_pkg::xlen_t old_val;
  core_pkg::xlen_t new_val;
  core_pkg::xlen_t result;
  core_pkg::pc_t   next_pc;
  logic [2:0]      funct3;
  logic [11:0]     csr;
  logic            writes;
  logic            csr_write;
  logic            mcycle_access;
  ins           = image[ref_pc[11:2]];
  funct3        = ins[14:12];
  csr           = ins[31:20];
  rs1_val       = ref_regs[ins[19:15]];
  next_pc       = ref_pc + 32'd4;
  result        = '0;
  src           = '0;
  old_val       = '0;
  new_val       = '0;
  writes        = 1'b0;
  csr_write     = 1'b0;
  mcycle_access = 1'b0;
  exp_pc           = ref_pc;
  exp_instr        = ins;
  exp_mcycle_write = 1'b0;
  exp_mcycle_floor = '0;
  exp_led_write    = 1'b0;
  case (ins[6:0])
    // op-imm, only addi belongs to the subset
    7'b0010011: begin
      if (funct3 == 3'b000) begin
        result = rs1_val + {{20{ins[31]}}, ins[31:20]};
        writes = 1'b1;
      end
    end
    // auipc
    7'b0010111: begin
      result = ref_pc + {ins[31:12], 12'h000};
      writes = 1'b1;
    end
    // jal, j-type offset
    7'b1101111: begin
      result  = ref_pc + 32'd4;
      writes  = 1'b1;
      next_pc = ref_pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    end
    // jalr, target lsb cleared
    7'b1100111: begin
      result  = ref_pc + 32'd4;
      writes  = 1'b1;
      next_pc = (rs1_val + {{20{ins[31]}}, ins[31:20]}) & ~32'd1;
    end
    // system, funct3 low bits pick rw/rs/rc and bit 2 the zimm form
    7'b1110011: begin
      if (funct3[1:0] != 2'b00) begin
        src = funct3[2] ? {27'd0, ins[19:15]} : rs1_val;
        case (csr)
          12'h350: old_val = ref_miselect;
          12'hB02: old_val = ref_instret;
          12'h7C0: old_val = ref_led;
          default: old_val = '0;
        endcase
        case (funct3[1:0])
          2'b01:   new_val = src;
          2'b10:   new_val = old_val | src;
          default: new_val = old_val & ~src;
        endcase
        csr_write     = (funct3[1:0] == 2'b01) || (src != '0);
        mcycle_access = (csr == 12'hB00);
        result        = old_val;
        writes        = 1'b1;
      end
    end
    default: ;
  endcase
  // no-ops retire without a destination
  exp_rd          = writes ? ins[11:7] : '0;
  exp_value       = (exp_rd != '0) ? result : '0;
  // mcycle reads are not predicted, the testbench adopts the dut value
  exp_mcycle_read = mcycle_access && (exp_rd != '0);
  if (exp_rd != '0 && !exp_mcycle_read) ref_regs[exp_rd] = result;
  if (csr_write) begin
    case (csr)
      12'h350: ref_miselect = new_val;
      12'h7C0: begin
        ref_led       = new_val;
        exp_led_write = 1'b1;
      end
      12'hB00: begin
        exp_mcycle_write = 1'b1;
        exp_mcycle_floor = (funct3[1:0] == 2'b01) ? src : '0;
      end
      default: ;
    endcase
  end
  // a minstret write replaces the count step of its own retire
  if (csr_write && csr == 12'hB02) ref_instret = new_val;
  else ref_instret = ref_instret + 32'd1;
  ref_pc = next_pc;
endtask

`endif

//--- dv/core_tb.sv
// core testbench: random retire credits, trace checks against the reference model
`default_nettype none

module core_tb;

  localparam int CLK_PERIOD        = 40;
  localparam int DRIVE_DELAY       = 2;
  localparam int RESET_CYCLES      = 8;
  localparam int FIRST_RUN         = 300;
  localparam int SECOND_RUN        = 100;
  localparam int CYCLES_PER_RETIRE = 8;
  // both runs at a generous retire rate plus the two reset phases
  localparam int WATCHDOG_TIME =
    ((FIRST_RUN + SECOND_RUN) * CYCLES_PER_RETIRE + 2 * (RESET_CYCLES + 2)) * CLK_PERIOD;

  logic              clk;
  logic              arst_n;
  logic              retire_credit;
  logic              retire_valid;
  core_pkg::retire_s retire;
  logic [7:0]        led;

  int              seed;
  int              checks;
  int              errors;
  int              errs_before;
  int              retired;
  // retires seen minus credits handed back
  int              outstanding;
  int unsigned     cycle_no;
  // cycle numbers at which a credit is due
  int unsigned     due_q[$];
  logic            hold_credits;
  core_pkg::xlen_t mcycle_floor;
  event            retire_seen;

  `include "core_model.svh"

  core_top uut (
    .clk           (clk),
    .arst_n        (arst_n),
    .retire_valid  (retire_valid),
    .retire        (retire),
    .retire_credit (retire_credit),
    .led           (led)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("mismatch %s: got 0x%08h expected 0x%08h", name, got, exp);
      errors++;
    end
  endtask

  // counter only moves forward, a write sets a new floor
  task automatic verify_mcycle(input core_pkg::xlen_t value);
    checks++;
    assert (value >= mcycle_floor) else begin
      $display("mcycle went backwards: read 0x%08h after 0x%08h", value, mcycle_floor);
      errors++;
    end
    mcycle_floor = value;
  endtask

  task automatic score_retire();
    int unsigned delay;
    step_model();
    compare_value("retire.pc", retire.pc, exp_pc);
    compare_value("retire.rd", 32'(retire.rd), 32'(exp_rd));
    compare_value("retire.instr", retire.instr, exp_instr);
    if (exp_mcycle_read) begin
      verify_mcycle(retire.value);
      ref_regs[exp_rd] = retire.value;
    end else begin
      compare_value("retire.value", retire.value, exp_value);
    end
    // read happens before the write of the same instruction
    if (exp_mcycle_write) mcycle_floor = exp_mcycle_floor;
    if (exp_led_write) compare_value("led", 32'(led), 32'(ref_led[7:0]));
    outstanding++;
    checks++;
    assert (outstanding >= 0 && outstanding <= int'(core_pkg::RETIRE_CREDITS)) else begin
      $display("retire seen with %0d retires still waiting for a credit", outstanding);
      errors++;
    end
    // credit comes back 0 to 3 cycles later
    delay = $unsigned($random(seed)) % 4;
    due_q.push_back(cycle_no + 1 + delay);
  endtask

  // at most one credit pulse per cycle, oldest matured entry first
  task automatic drive_credit();
    int pick;
    pick = -1;
    if (!hold_credits) begin
      foreach (due_q[i]) begin
        if (pick < 0 && due_q[i] <= cycle_no) pick = i;
      end
    end
    retire_credit = (pick >= 0);
    if (pick >= 0) begin
      due_q.delete(pick);
      outstanding--;
    end
  endtask

  task automatic apply_reset();
    hold_credits = 1'b1;
    @(posedge clk);
    #DRIVE_DELAY;
    arst_n = 1'b0;
    // credits owed before reset are lost with the dut counter
    due_q.delete();
    outstanding  = 0;
    retired      = 0;
    mcycle_floor = '0;
    reset_model();
    repeat (RESET_CYCLES) begin
      @(negedge clk);
      compare_value("retire_valid", 32'(retire_valid), 32'd0);
      compare_value("led", 32'(led), 32'd0);
    end
    @(posedge clk);
    #DRIVE_DELAY;
    arst_n       = 1'b1;
    hold_credits = 1'b0;
    // first cycle out of reset
    @(negedge clk);
    compare_value("retire_valid", 32'(retire_valid), 32'd0);
    compare_value("led", 32'(led), 32'd0);
  endtask

  task automatic wait_retires(input int count);
    while (retired < count) @(retire_seen);
  endtask

  task automatic report_test(input int num, input string what);
    $display("test %0d %s done, %0d errors", num, what, errors - errs_before);
  endtask

  // inputs change a little after the rising edge
  always @(posedge clk) begin
    #DRIVE_DELAY;
    cycle_no++;
    drive_credit();
  end

  // registered outputs are settled at the falling edge
  always @(negedge clk) begin
    if (arst_n && retire_valid) begin
      score_retire();
      retired++;
      -> retire_seen;
    end
  end

  initial begin
    #(WATCHDOG_TIME);
    $display("watchdog expired after %0d retires of the current run", retired);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    seed          = 32'hcbca_4767;
    arst_n        = 1'b0;
    retire_credit = 1'b0;
    hold_credits  = 1'b1;
    checks        = 0;
    errors        = 0;
    cycle_no      = 0;
    load_image();

    errs_before = errors;
    apply_reset();
    report_test(1, "reset state");

    errs_before = errors;
    wait_retires(FIRST_RUN);
    // stop handing out credits before the mid-run reset
    hold_credits = 1'b1;
    report_test(2, "trace of the first run");

    errs_before = errors;
    apply_reset();
    wait_retires(SECOND_RUN);
    report_test(3, "trace after the mid-run reset");

    $display("tests 3, checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
verilog/core_pkg.sv
verilog/rom.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/csr_file.sv
verilog/execute_stage.sv
verilog/core_top.sv
+incdir+dv
dv/core_tb.sv

//--- run.sh
#!/bin/sh
# compile the core testbench with verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module core_tb -Mdir obj_dir -f project.f

./obj_dir/Vcore_tb | tee sim.log

if grep -q "CHECKS FAILED" sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi
if ! grep -q "ALL CHECKS PASSED" sim.log; then
  echo "simulation ended without a result line, see sim.log"
  exit 1
fi
echo "simulation passed"

//--- verilog/program.hex
// one 32-bit instruction word per line, starting at word address 0
// comment after each word: byte address and instruction
00500093  // 0x00 addi   x1, x0, 5
35009173  // 0x04 csrrw  x2, miselect, x1
350021f3  // 0x08 csrrs  x3, miselect, x0
00000293  // 0x0c addi   x5, x0, 0
00128293  // 0x10 loop: addi x5, x5, 1
7c029373  // 0x14 csrrw  x6, led, x5
7c0863f3  // 0x18 csrrsi x7, led, 0x10
7c00f473  // 0x1c csrrci x8, led, 1
b0025073  // 0x20 csrrwi x0, mcycle, 4
b00024f3  // 0x24 csrrs  x9, mcycle, x0
b0202573  // 0x28 csrrs  x10, minstret, x0
00001597  // 0x2c auipc  x11, 1
0080066f  // 0x30 jal    x12, +8
06300693  // 0x34 addi   x13, x0, 99 (jumped over)
04400713  // 0x38 addi   x14, x0, 0x44
000707e7  // 0x3c jalr   x15, 0(x14)
04d00693  // 0x40 addi   x13, x0, 77 (jumped over)
0000058b  // 0x44 custom-0 opcode, retires as a nop
fc9ff06f  // 0x48 jal    x0, loop
00000013  // 0x4c nop, prefetch padding
00000013  // 0x50 nop, prefetch padding
00000013  // 0x54 nop, prefetch padding
